/* design/main_mem_settings.svh */
`ifndef MAIN_MEM_SETTINGS_SVH
`define MAIN_MEM_SETTINGS_SVH

////////////////////////////////////////////////////////////
// geometry of the banked memory

`define MM_WORD_W      64  // one ram word
`define MM_RAMS        8
`define MM_DEPTH       512
`define MM_ADDR_W      9
`define MM_INDEX_W     14  // logical index seen by clients
`define MM_ELEM_W      16

////////////////////////////////////////////////////////////
// region map, in ram words

`define MM_B_COLS      336 // words of B in each ram
`define MM_OFF_B       0
`define MM_OFF_RNG     426
`define MM_OFF_SALT    427
`define MM_OFF_SEED_SE 428
`define MM_OFF_PKH     429
`define MM_OFF_K       431

// read data appears this many edges after the request
`define MM_RD_LATENCY  2

`endif

/* design/main_mem_pkg.sv */
`default_nettype none
`include "main_mem_settings.svh"

package main_mem_pkg;

  typedef logic [`MM_INDEX_W-1:0] mem_index_t;
  typedef logic [`MM_ADDR_W-1:0]  ram_addr_t;
  typedef logic [`MM_RAMS-1:0]    ram_mask_t;  // per ram or per byte
  typedef logic [`MM_WORD_W-1:0]  ram_word_t;
  typedef logic [`MM_ELEM_W-1:0]  elem_t;

  // four elements, same width as a ram word
  typedef logic [(`MM_WORD_W / `MM_ELEM_W)*`MM_ELEM_W-1:0] bus_t;
  // one element per ram
  typedef logic [`MM_RAMS*`MM_ELEM_W-1:0] dub_bus_t;
  // all eight ram words side by side, lane r is ram r
  typedef logic [`MM_RAMS*`MM_WORD_W-1:0] lanes_t;

  typedef enum logic [2:0] {
    MODE_IDLE      = 3'd0,
    MODE_B_ROW     = 3'd1,
    MODE_B_COL     = 3'd2,
    MODE_RNG_STATE = 3'd3,
    MODE_SALT      = 3'd4,
    MODE_SEED_SE   = 3'd5,
    MODE_PKH       = 3'd6,
    MODE_K         = 3'd7
  } mem_mode_t;

  typedef struct packed {
    mem_mode_t  mode;
    mem_index_t index;
  } mem_req_t;

  typedef struct packed {
    ram_addr_t addr;
    ram_mask_t ram_en;
    ram_mask_t byte_en;
  } ram_access_t;

endpackage

`default_nettype wire

/* design/mem_access_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "main_mem_settings.svh"

module mem_access_decode (
  input  main_mem_pkg::mem_req_t    i_req,
  output main_mem_pkg::ram_access_t o_access,
  output main_mem_pkg::mem_index_t  o_next,
  output logic                      o_has_next
);

  localparam int unsigned sel_w      = $clog2(`MM_RAMS);
  localparam int unsigned elem_sel_w = $clog2(`MM_WORD_W / `MM_ELEM_W);
  localparam int unsigned row_sel_w  = `MM_INDEX_W - `MM_ADDR_W;

  localparam main_mem_pkg::mem_index_t row_last =
    main_mem_pkg::mem_index_t'((`MM_RAMS - 1) * `MM_DEPTH + `MM_B_COLS - 1);
  localparam main_mem_pkg::mem_index_t col_last =
    main_mem_pkg::mem_index_t'(`MM_B_COLS * (`MM_WORD_W / `MM_ELEM_W) - 1);
  localparam main_mem_pkg::mem_index_t state_last = main_mem_pkg::mem_index_t'(`MM_RAMS - 1);
  localparam main_mem_pkg::mem_index_t hash_last  = main_mem_pkg::mem_index_t'(3); // 256 bits

  main_mem_pkg::ram_addr_t  cell_off;
  main_mem_pkg::mem_index_t cell_last;
  logic                     is_cell;
  logic [sel_w-1:0]         row_ram;
  main_mem_pkg::ram_addr_t  row_word;
  main_mem_pkg::mem_index_t row_base;
  logic [elem_sel_w-1:0]    col_elem;
  main_mem_pkg::mem_index_t index_inc;

  assign row_ram   = i_req.index[`MM_ADDR_W +: sel_w];
  assign row_word  = i_req.index[`MM_ADDR_W-1:0];
  assign row_base  = {i_req.index[`MM_ADDR_W +: row_sel_w], {`MM_ADDR_W{1'b0}}};
  assign col_elem  = i_req.index[elem_sel_w-1:0];
  assign index_inc = i_req.index + main_mem_pkg::mem_index_t'(1);

  ////////////////////////////////////////////////////////////
  // single word state cells
  always_comb begin
    is_cell   = 1'b1;
    cell_off  = main_mem_pkg::ram_addr_t'(`MM_OFF_RNG);
    cell_last = state_last;
    case (i_req.mode)
      main_mem_pkg::MODE_RNG_STATE: cell_off = main_mem_pkg::ram_addr_t'(`MM_OFF_RNG);
      main_mem_pkg::MODE_SALT:      cell_off = main_mem_pkg::ram_addr_t'(`MM_OFF_SALT);
      main_mem_pkg::MODE_SEED_SE:   cell_off = main_mem_pkg::ram_addr_t'(`MM_OFF_SEED_SE);
      main_mem_pkg::MODE_PKH: begin
        cell_off  = main_mem_pkg::ram_addr_t'(`MM_OFF_PKH);
        cell_last = hash_last;
      end
      main_mem_pkg::MODE_K: begin
        cell_off  = main_mem_pkg::ram_addr_t'(`MM_OFF_K);
        cell_last = hash_last;
      end
      default: is_cell = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // address, masks and walk
  always_comb begin
    o_access   = '0;
    o_next     = index_inc;
    o_has_next = 1'b0;
    case (i_req.mode)
      main_mem_pkg::MODE_B_ROW: begin
        o_access.addr    = main_mem_pkg::ram_addr_t'(`MM_OFF_B) + row_word;
        o_access.ram_en  = main_mem_pkg::ram_mask_t'(1) << row_ram;
        o_access.byte_en = '1;
        if (row_word == main_mem_pkg::ram_addr_t'(`MM_B_COLS - 1)) begin
          o_next = row_base + main_mem_pkg::mem_index_t'(`MM_DEPTH); // wrap to next ram
        end
        o_has_next = (i_req.index != row_last);
      end
      main_mem_pkg::MODE_B_COL: begin
        o_access.addr    = main_mem_pkg::ram_addr_t'(`MM_OFF_B)
                         + i_req.index[elem_sel_w +: `MM_ADDR_W];
        o_access.ram_en  = '1;
        o_access.byte_en = main_mem_pkg::ram_mask_t'(2'b11) << {col_elem, 1'b0}; // 2 bytes/elem
        o_has_next       = (i_req.index != col_last);
      end
      default: begin
        if (is_cell) begin
          o_access.addr    = cell_off + main_mem_pkg::ram_addr_t'(i_req.index >> sel_w);
          o_access.ram_en  = main_mem_pkg::ram_mask_t'(1) << i_req.index[sel_w-1:0];
          o_access.byte_en = '1;
          o_has_next       = (i_req.index != cell_last);
        end
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/mem_bram_column.sv */
`timescale 1ns/1ps
`default_nettype none
`include "main_mem_settings.svh"

module mem_bram_column (
  input  logic                    clk,
  input  logic                    i_rd_en,
  input  main_mem_pkg::ram_addr_t i_rd_addr,
  output main_mem_pkg::ram_word_t o_rd_word,
  input  logic                    i_wr_en,
  input  main_mem_pkg::ram_mask_t i_wr_byte_en,
  input  main_mem_pkg::ram_addr_t i_wr_addr,
  input  main_mem_pkg::ram_word_t i_wr_word
);

  main_mem_pkg::ram_word_t mem [`MM_DEPTH];
  main_mem_pkg::ram_word_t rd_q1;
  main_mem_pkg::ram_word_t rd_q2;

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      for (int b = 0; b < `MM_WORD_W / 8; b++) begin
        if (i_wr_byte_en[b]) begin
          mem[i_wr_addr][b*8 +: 8] <= i_wr_word[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      rd_q1 <= mem[i_rd_addr]; // old data on collision
    end
    rd_q2 <= rd_q1; // output register
  end

  assign o_rd_word = rd_q2;

endmodule

`default_nettype wire

/* design/mem_bram_bank.sv */
`timescale 1ns/1ps
`default_nettype none
`include "main_mem_settings.svh"

module mem_bram_bank (
  input  logic                      clk,
  input  logic                      i_rst_n,
  input  main_mem_pkg::ram_access_t i_rd,
  output main_mem_pkg::lanes_t      o_rd_lanes,
  input  main_mem_pkg::ram_access_t i_wr,
  input  main_mem_pkg::lanes_t      i_wr_lanes
);

  localparam int unsigned bytes_w = `MM_WORD_W / 8;
  localparam int unsigned last    = `MM_RD_LATENCY - 1;

  main_mem_pkg::ram_mask_t [last:0] ram_en_d;
  main_mem_pkg::ram_mask_t [last:0] byte_en_d;
  main_mem_pkg::lanes_t             raw_lanes;

  ////////////////////////////////////////////////////////////
  // read masks follow the data through the ram pipeline
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ram_en_d  <= '0;
      byte_en_d <= '0;
    end else begin
      ram_en_d  <= {ram_en_d[last-1:0], i_rd.ram_en};
      byte_en_d <= {byte_en_d[last-1:0], i_rd.byte_en};
    end
  end

  ////////////////////////////////////////////////////////////
  for (genvar r = 0; r < `MM_RAMS; r++) begin : g_col
    mem_bram_column u_col (
      .clk          (clk),
      .i_rd_en      (i_rd.ram_en[r]),
      .i_rd_addr    (i_rd.addr),
      .o_rd_word    (raw_lanes[r*`MM_WORD_W +: `MM_WORD_W]),
      .i_wr_en      (i_wr.ram_en[r]),
      .i_wr_byte_en (i_wr.byte_en & {bytes_w{i_wr.ram_en[r]}}),
      .i_wr_addr    (i_wr.addr),
      .i_wr_word    (i_wr_lanes[r*`MM_WORD_W +: `MM_WORD_W])
    );

    for (genvar b = 0; b < bytes_w; b++) begin : g_byte
      assign o_rd_lanes[r*`MM_WORD_W + b*8 +: 8] =
        raw_lanes[r*`MM_WORD_W + b*8 +: 8] & {8{ram_en_d[last][r] & byte_en_d[last][b]}};
    end
  end

endmodule

`default_nettype wire

/* design/mem_write_pack.sv */
`timescale 1ns/1ps
`default_nettype none
`include "main_mem_settings.svh"

module mem_write_pack (
  input  main_mem_pkg::mem_req_t i_req,
  input  main_mem_pkg::bus_t     i_bus,
  input  main_mem_pkg::dub_bus_t i_dub,
  output main_mem_pkg::lanes_t   o_lanes
);

  localparam int unsigned elems = `MM_WORD_W / `MM_ELEM_W;

  // byte enables pick the slice, so every slice carries the element
  always_comb begin
    o_lanes = '0;
    case (i_req.mode)
      main_mem_pkg::MODE_IDLE: o_lanes = '0;
      main_mem_pkg::MODE_B_COL: begin
        for (int r = 0; r < `MM_RAMS; r++) begin
          o_lanes[r*`MM_WORD_W +: `MM_WORD_W] = {elems{i_dub[r*`MM_ELEM_W +: `MM_ELEM_W]}};
        end
      end
      default: o_lanes = {`MM_RAMS{i_bus}}; // ram enable picks the lane
    endcase
  end

endmodule

`default_nettype wire

/* design/mem_read_result.sv */
`timescale 1ns/1ps
`default_nettype none
`include "main_mem_settings.svh"

module mem_read_result (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  main_mem_pkg::mem_mode_t i_mode,
  input  main_mem_pkg::lanes_t    i_lanes,
  output main_mem_pkg::bus_t      o_bus,
  output main_mem_pkg::dub_bus_t  o_dub
);

  localparam int unsigned elems = `MM_WORD_W / `MM_ELEM_W;

  main_mem_pkg::mem_mode_t mode_d [`MM_RD_LATENCY];
  main_mem_pkg::mem_mode_t rd_mode;
  main_mem_pkg::bus_t      bus_or;
  main_mem_pkg::dub_bus_t  dub_or;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `MM_RD_LATENCY; i++) begin
        mode_d[i] <= main_mem_pkg::MODE_IDLE;
      end
    end else begin
      mode_d[0] <= i_mode;
      for (int i = 1; i < `MM_RD_LATENCY; i++) begin
        mode_d[i] <= mode_d[i-1];
      end
    end
  end

  assign rd_mode = mode_d[`MM_RD_LATENCY-1];

  // unselected lanes are already zero
  always_comb begin
    bus_or = '0;
    for (int r = 0; r < `MM_RAMS; r++) begin
      bus_or = bus_or | i_lanes[r*`MM_WORD_W +: `MM_WORD_W];
    end
  end

  // one element per ram, only one slice survives the byte mask
  always_comb begin
    dub_or = '0;
    for (int r = 0; r < `MM_RAMS; r++) begin
      for (int s = 0; s < elems; s++) begin
        dub_or[r*`MM_ELEM_W +: `MM_ELEM_W] = dub_or[r*`MM_ELEM_W +: `MM_ELEM_W]
          | i_lanes[r*`MM_WORD_W + s*`MM_ELEM_W +: `MM_ELEM_W];
      end
    end
  end

  always_comb begin
    o_bus = '0;
    o_dub = '0;
    case (rd_mode)
      main_mem_pkg::MODE_B_COL: o_dub = dub_or;
      main_mem_pkg::MODE_IDLE:  o_bus = '0;
      default:                  o_bus = bus_or; // row and cells
    endcase
  end

endmodule

`default_nettype wire

/* design/main_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module main_mem (
  input  logic                     clk,
  input  logic                     i_rst_n,

  input  main_mem_pkg::mem_req_t   i_rd_req,
  output main_mem_pkg::mem_index_t o_rd_next,
  output logic                     o_rd_has_next,
  output main_mem_pkg::bus_t       o_rd_bus,
  output main_mem_pkg::dub_bus_t   o_rd_dub,

  input  main_mem_pkg::mem_req_t   i_wr_req,
  input  main_mem_pkg::bus_t       i_wr_bus,
  input  main_mem_pkg::dub_bus_t   i_wr_dub,
  output main_mem_pkg::mem_index_t o_wr_next,
  output logic                     o_wr_has_next
);

  main_mem_pkg::ram_access_t rd_access;
  main_mem_pkg::ram_access_t wr_access;
  main_mem_pkg::lanes_t      wr_lanes;
  main_mem_pkg::lanes_t      rd_lanes;

  ////////////////////////////////////////////////////////////
  // read port
  mem_access_decode u_rd_decode (
    .i_req      (i_rd_req),
    .o_access   (rd_access),
    .o_next     (o_rd_next),
    .o_has_next (o_rd_has_next)
  );

  mem_read_result u_rd_result (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_mode  (i_rd_req.mode),
    .i_lanes (rd_lanes),
    .o_bus   (o_rd_bus),
    .o_dub   (o_rd_dub)
  );

  ////////////////////////////////////////////////////////////
  // write port
  mem_access_decode u_wr_decode (
    .i_req      (i_wr_req),
    .o_access   (wr_access),
    .o_next     (o_wr_next),
    .o_has_next (o_wr_has_next)
  );

  mem_write_pack u_wr_pack (
    .i_req   (i_wr_req),
    .i_bus   (i_wr_bus),
    .i_dub   (i_wr_dub),
    .o_lanes (wr_lanes)
  );

  mem_bram_bank u_bank (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_rd       (rd_access),
    .o_rd_lanes (rd_lanes),
    .i_wr       (wr_access),
    .i_wr_lanes (wr_lanes)
  );

endmodule

`default_nettype wire

/* verif/main_mem_props.sv */
`timescale 1ns/1ps
`default_nettype none

module main_mem_props (
  input logic                     clk,
  input logic                     i_rst_n,
  input main_mem_pkg::mem_req_t   i_rd_req,
  input logic                     o_rd_has_next,
  input main_mem_pkg::bus_t       o_rd_bus,
  input main_mem_pkg::dub_bus_t   o_rd_dub,
  input main_mem_pkg::mem_req_t   i_wr_req,
  input main_mem_pkg::mem_index_t o_wr_next
);

  logic rd_idle;
  logic wr_cell;

  assign rd_idle = (i_rd_req.mode == main_mem_pkg::MODE_IDLE);
  assign wr_cell = (i_wr_req.mode >= main_mem_pkg::MODE_RNG_STATE); // cells end the enum

  idle_no_next: assert property (@(posedge clk) disable iff (!i_rst_n)
    rd_idle |-> !o_rd_has_next)
    else $error("read has-next high for an idle request");

  // data from the request at one edge is sampled two edges later
  idle_reads_zero: assert property (@(posedge clk) disable iff (!i_rst_n)
    rd_idle |-> ##2 (o_rd_bus == '0 && o_rd_dub == '0))
    else $error("read outputs not zero after an idle read");

  cell_next_inc: assert property (@(posedge clk) disable iff (!i_rst_n)
    wr_cell |-> (o_wr_next == i_wr_req.index + main_mem_pkg::mem_index_t'(1)))
    else $error("write next index is not index plus one for a cell");

endmodule

bind main_mem main_mem_props u_props (
  .clk           (clk),
  .i_rst_n       (i_rst_n),
  .i_rd_req      (i_rd_req),
  .o_rd_has_next (o_rd_has_next),
  .o_rd_bus      (o_rd_bus),
  .o_rd_dub      (o_rd_dub),
  .i_wr_req      (i_wr_req),
  .o_wr_next     (o_wr_next)
);

`default_nettype wire

/* verif/main_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "main_mem_settings.svh"

module main_mem_tb;

  localparam int clk_period = 10;
  localparam int elems      = `MM_WORD_W / `MM_ELEM_W;
  localparam int drain      = `MM_RD_LATENCY;  // ticks until the last read is checked
  localparam int walk_len   = 2 + (`MM_RAMS - 1) * `MM_B_COLS; // ram 0 word 334 to the end
  localparam int test_ticks = (2 * 32 + drain) + (2 * walk_len + drain) + (40 + drain)
                            + (17 + drain) + (24 + drain);
  localparam int timeout_ns = clk_period * (4 + test_ticks + 100);
  localparam main_mem_pkg::mem_req_t idle_req = '0;

  typedef struct packed {
    main_mem_pkg::bus_t     bus;
    main_mem_pkg::dub_bus_t dub;
  } rd_result_t;

  logic                     clk;
  logic                     i_rst_n;
  main_mem_pkg::mem_req_t   i_rd_req;
  main_mem_pkg::mem_index_t o_rd_next;
  logic                     o_rd_has_next;
  main_mem_pkg::bus_t       o_rd_bus;
  main_mem_pkg::dub_bus_t   o_rd_dub;
  main_mem_pkg::mem_req_t   i_wr_req;
  main_mem_pkg::bus_t       i_wr_bus;
  main_mem_pkg::dub_bus_t   i_wr_dub;
  main_mem_pkg::mem_index_t o_wr_next;
  logic                     o_wr_has_next;

  main_mem_pkg::ram_word_t ref_mem [`MM_RAMS][`MM_DEPTH];
  rd_result_t              exp_q [$];  // one entry per read still in flight
  int                      err_count;

  main_mem uut (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_rd_req      (i_rd_req),
    .o_rd_next     (o_rd_next),
    .o_rd_has_next (o_rd_has_next),
    .o_rd_bus      (o_rd_bus),
    .o_rd_dub      (o_rd_dub),
    .i_wr_req      (i_wr_req),
    .i_wr_bus      (i_wr_bus),
    .i_wr_dub      (i_wr_dub),
    .o_wr_next     (o_wr_next),
    .o_wr_has_next (o_wr_has_next)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic main_mem_pkg::mem_req_t make_req(main_mem_pkg::mem_mode_t mode, int index);
    main_mem_pkg::mem_req_t req;
    req.mode  = mode;
    req.index = main_mem_pkg::mem_index_t'(index);
    return req;
  endfunction

  function automatic main_mem_pkg::ram_word_t rand_word();
    return {$urandom, $urandom};
  endfunction

  ////////////////////////////////////////////////////////////
  // reference memory, reads return data, writes update it
  function automatic rd_result_t access_model(main_mem_pkg::mem_req_t req, logic wr,
                                              main_mem_pkg::bus_t bus,
                                              main_mem_pkg::dub_bus_t dub);
    rd_result_t res;
    int         idx;
    int         ram;
    int         addr;
    idx = int'(req.index);
    res = '0;
    ram = idx % `MM_RAMS;  // cells interleave over the rams
    case (req.mode)
      main_mem_pkg::MODE_B_ROW: begin
        ram  = idx / `MM_DEPTH;
        addr = `MM_OFF_B + idx % `MM_DEPTH;
      end
      main_mem_pkg::MODE_RNG_STATE: addr = `MM_OFF_RNG + idx / `MM_RAMS;
      main_mem_pkg::MODE_SALT:      addr = `MM_OFF_SALT + idx / `MM_RAMS;
      main_mem_pkg::MODE_SEED_SE:   addr = `MM_OFF_SEED_SE + idx / `MM_RAMS;
      main_mem_pkg::MODE_PKH:       addr = `MM_OFF_PKH + idx / `MM_RAMS;
      main_mem_pkg::MODE_K:         addr = `MM_OFF_K + idx / `MM_RAMS;
      default:                      addr = `MM_OFF_B + idx / elems; // column word
    endcase
    if (req.mode == main_mem_pkg::MODE_B_COL) begin
      for (int r = 0; r < `MM_RAMS; r++) begin
        if (wr) begin
          ref_mem[r][addr][(idx % elems)*`MM_ELEM_W +: `MM_ELEM_W] =
            dub[r*`MM_ELEM_W +: `MM_ELEM_W];
        end else begin
          res.dub[r*`MM_ELEM_W +: `MM_ELEM_W] =
            ref_mem[r][addr][(idx % elems)*`MM_ELEM_W +: `MM_ELEM_W];
        end
      end
    end else if (req.mode != main_mem_pkg::MODE_IDLE) begin
      if (wr) begin
        ref_mem[ram][addr] = bus;
      end else begin
        res.bus = ref_mem[ram][addr];
      end
    end
    return res;
  endfunction

  task automatic check(string name, logic [127:0] actual, logic [127:0] expected);
    if (actual !== expected) begin
      err_count++;
      $display("error %s: got %h, expected %h", name, actual, expected);
      $display("Errors found");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // read port walk step, next index only matters while has-next is high
  task automatic compare_read_next(main_mem_pkg::mem_req_t req);
    int   idx;
    int   last;
    int   exp_next;
    logic exp_more;
    idx      = int'(req.index);
    exp_next = idx + 1;
    case (req.mode)
      main_mem_pkg::MODE_B_ROW: begin
        last = (`MM_RAMS - 1) * `MM_DEPTH + `MM_B_COLS - 1;
        if (idx % `MM_DEPTH == `MM_B_COLS - 1) begin
          exp_next = (idx / `MM_DEPTH + 1) * `MM_DEPTH; // word 0 of the next ram
        end
      end
      main_mem_pkg::MODE_B_COL:                     last = `MM_B_COLS * elems - 1;
      main_mem_pkg::MODE_PKH, main_mem_pkg::MODE_K: last = 3;
      default:                                      last = `MM_RAMS - 1;
    endcase
    exp_more = (req.mode != main_mem_pkg::MODE_IDLE) && (idx != last);
    check("o_rd_has_next", 128'(o_rd_has_next), 128'(exp_more));
    if (exp_more) begin
      check("o_rd_next", 128'(o_rd_next), 128'(exp_next));
    end
  endtask

  // one falling edge: check the read issued two edges back, then drive
  task automatic tick(main_mem_pkg::mem_req_t rd, main_mem_pkg::mem_req_t wr,
                      main_mem_pkg::bus_t bus, main_mem_pkg::dub_bus_t dub);
    rd_result_t exp;
    @(negedge clk);
    exp = exp_q.pop_front();
    check("o_rd_bus", 128'(o_rd_bus), 128'(exp.bus));
    check("o_rd_dub", o_rd_dub, exp.dub);
    i_rd_req = rd;
    i_wr_req = wr;
    i_wr_bus = bus;
    i_wr_dub = dub;
    exp_q.push_back(access_model(rd, 1'b0, '0, '0)); // old data on collision
    void'(access_model(wr, 1'b1, bus, dub));
    #1;
    compare_read_next(rd);
  endtask

  task automatic drain_pipe();
    repeat (drain) tick(idle_req, idle_req, '0, '0);
  endtask

  ////////////////////////////////////////////////////////////
  task automatic cell_round_trip();
    main_mem_pkg::mem_mode_t modes [5];
    int                      last;
    modes = '{main_mem_pkg::MODE_RNG_STATE, main_mem_pkg::MODE_SALT,
              main_mem_pkg::MODE_SEED_SE, main_mem_pkg::MODE_PKH, main_mem_pkg::MODE_K};
    for (int phase = 0; phase < 2; phase++) begin
      foreach (modes[m]) begin
        last = (modes[m] >= main_mem_pkg::MODE_PKH) ? 3 : `MM_RAMS - 1;
        for (int i = 0; i <= last; i++) begin
          if (phase == 0) begin
            tick(idle_req, make_req(modes[m], i), rand_word(), '0);
            #1;
            check("o_wr_has_next", 128'(o_wr_has_next), 128'(i != last));
          end else begin
            tick(make_req(modes[m], i), idle_req, '0, '0);
          end
        end
      end
    end
    drain_pipe();
  endtask

  task automatic row_walk();
    main_mem_pkg::mem_index_t walk [$];
    main_mem_pkg::mem_index_t idx;
    int                       exp_next;
    logic                     more;
    idx  = main_mem_pkg::mem_index_t'(`MM_B_COLS - 2);
    more = 1'b1;
    while (more) begin
      tick(idle_req, make_req(main_mem_pkg::MODE_B_ROW, int'(idx)), rand_word(), '0);
      #1;
      walk.push_back(idx);
      more     = (int'(idx) != (`MM_RAMS - 1) * `MM_DEPTH + `MM_B_COLS - 1);
      exp_next = (int'(idx) % `MM_DEPTH == `MM_B_COLS - 1) ?
                 (int'(idx) / `MM_DEPTH + 1) * `MM_DEPTH : int'(idx) + 1;
      check("o_wr_has_next", 128'(o_wr_has_next), 128'(more));
      if (more) begin
        check("o_wr_next", 128'(o_wr_next), 128'(exp_next));
        idx = o_wr_next;
      end
    end
    check("walk length", 128'(walk.size()), 128'(walk_len));
    check("index after word 335", 128'(walk[2]), 128'(`MM_DEPTH));
    foreach (walk[i]) begin
      tick(make_req(main_mem_pkg::MODE_B_ROW, int'(walk[i])), idle_req, '0, '0);
    end
    drain_pipe();
  endtask

  task automatic column_view();
    for (int k = 0; k < 16; k++) begin
      tick(idle_req, make_req(main_mem_pkg::MODE_B_COL, k), '0, {rand_word(), rand_word()});
    end
    for (int k = 0; k < 16; k++) begin
      tick(make_req(main_mem_pkg::MODE_B_COL, k), idle_req, '0, '0);
    end
    for (int r = 0; r < `MM_RAMS; r++) begin
      tick(make_req(main_mem_pkg::MODE_B_ROW, r * `MM_DEPTH + 2), idle_req, '0, '0);
    end
    drain_pipe();
  endtask

  task automatic partial_write();
    for (int r = 0; r < `MM_RAMS; r++) begin
      tick(idle_req, make_req(main_mem_pkg::MODE_B_ROW, r * `MM_DEPTH + 10), rand_word(), '0);
    end
    // read and column write of the same word on one edge
    tick(make_req(main_mem_pkg::MODE_B_ROW, 2 * `MM_DEPTH + 10),
         make_req(main_mem_pkg::MODE_B_COL, 10 * elems + 1), '0, {rand_word(), rand_word()});
    for (int r = 0; r < `MM_RAMS; r++) begin
      tick(make_req(main_mem_pkg::MODE_B_ROW, r * `MM_DEPTH + 10), idle_req, '0, '0);
    end
    drain_pipe();
  endtask

  task automatic pipelined_reads();
    main_mem_pkg::mem_mode_t mode;
    int                      index;
    for (int n = 0; n < 24; n++) begin
      mode = main_mem_pkg::mem_mode_t'(n[2:0]); // every mode in turn, idle too
      case (mode)
        main_mem_pkg::MODE_B_ROW:
          index = int'(1 + $urandom % 7) * `MM_DEPTH + int'($urandom % `MM_B_COLS);
        main_mem_pkg::MODE_B_COL:                     index = int'($urandom % 16);
        main_mem_pkg::MODE_PKH, main_mem_pkg::MODE_K: index = int'($urandom % 4);
        default:                                      index = int'($urandom % `MM_RAMS);
      endcase
      tick(make_req(mode, index), idle_req, '0, '0);
    end
    drain_pipe();
  endtask

  ////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(32'hedfc));
    clk       = 1'b0;
    i_rst_n   = 1'b0;
    i_rd_req  = idle_req;
    i_wr_req  = idle_req;
    i_wr_bus  = '0;
    i_wr_dub  = '0;
    err_count = 0;
    repeat (drain) exp_q.push_back('0);
    repeat (4) @(negedge clk);
    i_rst_n = 1'b1;
    cell_round_trip();
    row_walk();
    column_view();
    partial_write();
    pipelined_reads();
    if (err_count == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1, "checks failed");
    end
  end

  initial begin
    #(timeout_ns);
    $display("Errors found");
    $fatal(1, "watchdog timeout, the tests did not finish in time");
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/main_mem_pkg.sv
design/mem_access_decode.sv
design/mem_bram_column.sv
design/mem_bram_bank.sv
design/mem_write_pack.sv
design/mem_read_result.sv
design/main_mem.sv
verif/main_mem_props.sv
verif/main_mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the main memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f sim.f --top-module main_mem_tb \
  -Mdir "$build_dir" -o main_mem_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$build_dir/main_mem_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "No errors" "$log_file"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
